// ==== vmul_macros.svh ====
`ifndef VMUL_MACROS_SVH
`define VMUL_MACROS_SVH

//////////////////////////////////////////////////
// datapath sizing
//////////////////////////////////////////////////

// operand and result width
`define VMUL_XLEN 64

// number of 8-bit lanes in one operand
`define VMUL_BYTE_LANES 8

// width of the smallest multiplier cell
// all wider lane products are built from these
`define VMUL_BASE_W 8

`endif

// ==== vmul_op_pkg.sv ====
package vmul_op_pkg;

    //////////////////////////////////////////////////
    // operation encodings
    //////////////////////////////////////////////////

    // supported multiply operations
    // the h forms return the high half of the product
    // the w forms return double-width products of the low lanes
    // in the su forms vs2 is signed and vs1 unsigned
    typedef enum logic [2:0] {
        VMUL    = 3'd0,
        VMULH   = 3'd1,
        VMULHU  = 3'd2,
        VMULHSU = 3'd3,
        VWMUL   = 3'd4,
        VWMULU  = 3'd5,
        VWMULSU = 3'd6
    } vmul_op_e;

    // selected element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

endpackage

// ==== vmul_data_pkg.sv ====
`include "vmul_macros.svh"

package vmul_data_pkg;

    //////////////////////////////////////////////////
    // data shapes
    //////////////////////////////////////////////////

    // one full operand or result vector
    typedef logic [`VMUL_XLEN-1:0] vreg_t;

    // one flag per byte lane
    // bit i set means lane i result must be negated
    typedef logic [`VMUL_BYTE_LANES-1:0] lane_mask_t;

    // one partial product
    // holds a 32x32 product or a slice of packed lane products
    typedef logic [`VMUL_XLEN-1:0] wprod_t;

    // product bank between stage 2 and result assembly
    // narrow widths pack diagonal lane products into the low 128 bits
    // SEW_64 holds lo*lo, lo*hi, hi*lo and hi*hi in entries 0 to 3
    typedef wprod_t [3:0] prod_bank_t;

endpackage

// ==== vmul_operand_prep.sv ====
`timescale 1ns/100ps

`include "vmul_macros.svh"

module vmul_operand_prep (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  vmul_op_pkg::vmul_op_e     op_i,
    input  vmul_op_pkg::sew_e         sew_i,
    input  vmul_data_pkg::vreg_t      vs1_i,
    input  vmul_data_pkg::vreg_t      vs2_i,
    output vmul_data_pkg::vreg_t      mag1_o,
    output vmul_data_pkg::vreg_t      mag2_o,
    output vmul_data_pkg::lane_mask_t neg_o,
    output vmul_op_pkg::sew_e         sew_o,
    output logic                      is_high_o,
    output logic                      is_wide_o
);

    import vmul_op_pkg::*;
    import vmul_data_pkg::*;

    //////////////////////////////////////////////////
    // operation decode
    //////////////////////////////////////////////////

    logic src1_signed;
    logic src2_signed;
    logic is_high_d;
    logic is_wide_d;

    // vs1 is unsigned in the su variants
    assign src1_signed = op_i inside {VMUL, VMULH, VWMUL};
    assign src2_signed = op_i inside {VMUL, VMULH, VMULHSU, VWMUL, VWMULSU};
    assign is_high_d   = op_i inside {VMULH, VMULHU, VMULHSU};
    assign is_wide_d   = op_i inside {VWMUL, VWMULU, VWMULSU};

    //////////////////////////////////////////////////
    // lane magnitudes
    //////////////////////////////////////////////////

    vreg_t      mag1_d;
    vreg_t      mag2_d;
    lane_mask_t neg_d;

    // negative signed lanes are negated so the array only sees magnitudes
    always_comb begin
        logic n1;
        logic n2;
        mag1_d = '0;
        mag2_d = '0;
        neg_d  = '0;
        n1     = 1'b0;
        n2     = 1'b0;
        unique case (sew_i)
            SEW_8: begin
                for (int i = 0; i < `VMUL_BYTE_LANES; i++) begin
                    n1 = src1_signed & vs1_i[i*8+7];
                    n2 = src2_signed & vs2_i[i*8+7];
                    neg_d[i] = n1 ^ n2;
                    mag1_d[i*8+:8] = n1 ? (~vs1_i[i*8+:8] + 8'd1) : vs1_i[i*8+:8];
                    mag2_d[i*8+:8] = n2 ? (~vs2_i[i*8+:8] + 8'd1) : vs2_i[i*8+:8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < `VMUL_BYTE_LANES/2; i++) begin
                    n1 = src1_signed & vs1_i[i*16+15];
                    n2 = src2_signed & vs2_i[i*16+15];
                    neg_d[i] = n1 ^ n2;
                    mag1_d[i*16+:16] = n1 ? (~vs1_i[i*16+:16] + 16'd1) : vs1_i[i*16+:16];
                    mag2_d[i*16+:16] = n2 ? (~vs2_i[i*16+:16] + 16'd1) : vs2_i[i*16+:16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < `VMUL_BYTE_LANES/4; i++) begin
                    n1 = src1_signed & vs1_i[i*32+31];
                    n2 = src2_signed & vs2_i[i*32+31];
                    neg_d[i] = n1 ^ n2;
                    mag1_d[i*32+:32] = n1 ? (~vs1_i[i*32+:32] + 32'd1) : vs1_i[i*32+:32];
                    mag2_d[i*32+:32] = n2 ? (~vs2_i[i*32+:32] + 32'd1) : vs2_i[i*32+:32];
                end
            end
            SEW_64: begin
                n1 = src1_signed & vs1_i[63];
                n2 = src2_signed & vs2_i[63];
                neg_d[0] = n1 ^ n2;
                mag1_d = n1 ? (~vs1_i + 64'd1) : vs1_i;
                mag2_d = n2 ? (~vs2_i + 64'd1) : vs2_i;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // stage 1 register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mag1_o    <= '0;
            mag2_o    <= '0;
            neg_o     <= '0;
            sew_o     <= SEW_8;
            is_high_o <= 1'b0;
            is_wide_o <= 1'b0;
        end else begin
            mag1_o    <= mag1_d;
            mag2_o    <= mag2_d;
            neg_o     <= neg_d;
            sew_o     <= sew_i;
            is_high_o <= is_high_d;
            is_wide_o <= is_wide_d;
        end
    end

    // width select drives every lane mux and must always be known
    sew_known_a: assert property (
        @(posedge clk_i) disable iff (!rstn_i) !$isunknown(sew_i)
    );

endmodule

// ==== vmul_partial_array.sv ====
`timescale 1ns/100ps

`include "vmul_macros.svh"

module vmul_partial_array (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  vmul_data_pkg::vreg_t      mag1_i,
    input  vmul_data_pkg::vreg_t      mag2_i,
    input  vmul_data_pkg::lane_mask_t neg_i,
    input  vmul_op_pkg::sew_e         sew_i,
    input  logic                      is_high_i,
    input  logic                      is_wide_i,
    output vmul_data_pkg::prod_bank_t prod_o,
    output vmul_data_pkg::lane_mask_t neg_o,
    output vmul_op_pkg::sew_e         sew_o,
    output logic                      is_high_o,
    output logic                      is_wide_o
);

    import vmul_op_pkg::*;
    import vmul_data_pkg::*;

    localparam int BW = `VMUL_BASE_W;
    localparam int NL = `VMUL_BYTE_LANES;

    //////////////////////////////////////////////////
    // byte product array
    //////////////////////////////////////////////////

    logic [2*BW-1:0] p8  [NL][NL];
    logic [4*BW-1:0] p16 [NL/2][NL/2];
    wprod_t          p32 [NL/4][NL/4];

    // every byte of mag1 against every byte of mag2
    always_comb begin
        for (int i = 0; i < NL; i++) begin
            for (int j = 0; j < NL; j++) begin
                p8[i][j] = mag1_i[i*BW+:BW] * mag2_i[j*BW+:BW];
            end
        end
    end

    // 16-bit products from four byte products
    // lo*lo + (lo*hi + hi*lo) << 8 + hi*hi << 16
    always_comb begin
        for (int i = 0; i < NL/2; i++) begin
            for (int j = 0; j < NL/2; j++) begin
                p16[i][j] = p8[2*i][2*j]
                          + ((p8[2*i][2*j+1] + p8[2*i+1][2*j]) << BW)
                          + (p8[2*i+1][2*j+1] << (2*BW));
            end
        end
    end

    // 32-bit products by the same scheme one level up
    always_comb begin
        for (int i = 0; i < NL/4; i++) begin
            for (int j = 0; j < NL/4; j++) begin
                p32[i][j] = p16[2*i][2*j]
                          + ((p16[2*i][2*j+1] + p16[2*i+1][2*j]) << (2*BW))
                          + (p16[2*i+1][2*j+1] << (4*BW));
            end
        end
    end

    //////////////////////////////////////////////////
    // bank packing
    //////////////////////////////////////////////////

    logic [4*`VMUL_XLEN-1:0] bank_d;

    always_comb begin
        bank_d = '0;
        unique case (sew_i)
            SEW_8: begin
                for (int i = 0; i < NL; i++) bank_d[i*2*BW+:2*BW] = p8[i][i];
            end
            SEW_16: begin
                for (int i = 0; i < NL/2; i++) bank_d[i*4*BW+:4*BW] = p16[i][i];
            end
            SEW_32: begin
                for (int i = 0; i < NL/4; i++) bank_d[i*8*BW+:8*BW] = p32[i][i];
            end
            // cross products for the 64x64 sum downstream
            SEW_64: begin
                bank_d[0*`VMUL_XLEN+:`VMUL_XLEN] = p32[0][0];
                bank_d[1*`VMUL_XLEN+:`VMUL_XLEN] = p32[0][1];
                bank_d[2*`VMUL_XLEN+:`VMUL_XLEN] = p32[1][0];
                bank_d[3*`VMUL_XLEN+:`VMUL_XLEN] = p32[1][1];
            end
        endcase
    end

    //////////////////////////////////////////////////
    // stage 2 register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prod_o    <= '0;
            neg_o     <= '0;
            sew_o     <= SEW_8;
            is_high_o <= 1'b0;
            is_wide_o <= 1'b0;
        end else begin
            prod_o    <= bank_d;
            neg_o     <= neg_i;
            sew_o     <= sew_i;
            is_high_o <= is_high_i;
            is_wide_o <= is_wide_i;
        end
    end

    // a single 64-bit lane only ever carries one sign flag
    sew64_single_neg_a: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (sew_i == SEW_64) |-> (neg_i[NL-1:1] == '0)
    );

endmodule

// ==== vmul_result_assemble.sv ====
`timescale 1ns/100ps

`include "vmul_macros.svh"

module vmul_result_assemble (
    input  vmul_data_pkg::prod_bank_t prod_i,
    input  vmul_data_pkg::lane_mask_t neg_i,
    input  vmul_op_pkg::sew_e         sew_i,
    input  logic                      is_high_i,
    input  logic                      is_wide_i,
    output vmul_data_pkg::vreg_t      vd_o
);

    import vmul_op_pkg::*;
    import vmul_data_pkg::*;

    localparam int XL = `VMUL_XLEN;

    logic [4*XL-1:0] bank;

    assign bank = prod_i;

    //////////////////////////////////////////////////
    // 64x64 product
    //////////////////////////////////////////////////

    logic [2*XL-1:0] prod_128;
    logic [2*XL-1:0] full_128;

    // lo*lo + (lo*hi + hi*lo) << 32 + hi*hi << 64
    assign prod_128 = bank[0*XL+:XL]
                    + ((bank[1*XL+:XL] + bank[2*XL+:XL]) << (XL/2))
                    + (bank[3*XL+:XL] << XL);

    assign full_128 = neg_i[0] ? (~prod_128 + 1'b1) : prod_128;

    //////////////////////////////////////////////////
    // sign restore and result select
    //////////////////////////////////////////////////

    always_comb begin
        logic [15:0] f8;
        logic [31:0] f16;
        logic [63:0] f32;
        vd_o = '0;
        f8   = '0;
        f16  = '0;
        f32  = '0;
        unique case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    f8 = neg_i[i] ? (~bank[i*16+:16] + 16'd1) : bank[i*16+:16];
                    if (is_wide_i) begin
                        // only the low four lanes fit when widened
                        if (i < 4) vd_o[i*16+:16] = f8;
                    end else begin
                        vd_o[i*8+:8] = is_high_i ? f8[15:8] : f8[7:0];
                    end
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    f16 = neg_i[i] ? (~bank[i*32+:32] + 32'd1) : bank[i*32+:32];
                    if (is_wide_i) begin
                        if (i < 2) vd_o[i*32+:32] = f16;
                    end else begin
                        vd_o[i*16+:16] = is_high_i ? f16[31:16] : f16[15:0];
                    end
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    f32 = neg_i[i] ? (~bank[i*64+:64] + 64'd1) : bank[i*64+:64];
                    if (is_wide_i) begin
                        if (i < 1) vd_o = f32;
                    end else begin
                        vd_o[i*32+:32] = is_high_i ? f32[63:32] : f32[31:0];
                    end
                end
            end
            // widened results fall back to the low half with no wider destination
            SEW_64: begin
                vd_o = is_high_i ? full_128[2*XL-1:XL] : full_128[XL-1:0];
            end
        endcase
    end

endmodule

// ==== vmul_top.sv ====
`timescale 1ns/100ps

module vmul_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  vmul_op_pkg::vmul_op_e op_i,
    input  vmul_op_pkg::sew_e     sew_i,
    input  vmul_data_pkg::vreg_t  vs1_i,
    input  vmul_data_pkg::vreg_t  vs2_i,
    output vmul_data_pkg::vreg_t  vd_o
);

    import vmul_op_pkg::*;
    import vmul_data_pkg::*;

    // stage 1 outputs
    vreg_t      mag1;
    vreg_t      mag2;
    lane_mask_t neg_1;
    sew_e       sew_1;
    logic       is_high_1;
    logic       is_wide_1;

    // stage 2 outputs
    prod_bank_t prod;
    lane_mask_t neg_2;
    sew_e       sew_2;
    logic       is_high_2;
    logic       is_wide_2;

    //////////////////////////////////////////////////
    // pipeline
    //////////////////////////////////////////////////

    vmul_operand_prep vmul_operand_prep_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .mag1_o    (mag1),
        .mag2_o    (mag2),
        .neg_o     (neg_1),
        .sew_o     (sew_1),
        .is_high_o (is_high_1),
        .is_wide_o (is_wide_1)
    );

    vmul_partial_array vmul_partial_array_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .mag1_i    (mag1),
        .mag2_i    (mag2),
        .neg_i     (neg_1),
        .sew_i     (sew_1),
        .is_high_i (is_high_1),
        .is_wide_i (is_wide_1),
        .prod_o    (prod),
        .neg_o     (neg_2),
        .sew_o     (sew_2),
        .is_high_o (is_high_2),
        .is_wide_o (is_wide_2)
    );

    // result follows the stage 2 register combinationally
    vmul_result_assemble vmul_result_assemble_i (
        .prod_i    (prod),
        .neg_i     (neg_2),
        .sew_i     (sew_2),
        .is_high_i (is_high_2),
        .is_wide_i (is_wide_2),
        .vd_o      (vd_o)
    );

endmodule

// ==== tb_vmul_top.sv ====
`timescale 1ns/100ps

module tb_vmul_top;

    import vmul_op_pkg::*;
    import vmul_data_pkg::*;

    localparam int NUM_RANDOM    = 120;
    localparam int RESET_TIMEOUT = 10;

    logic     clk_i;
    logic     rstn_i;
    vmul_op_e op_i;
    sew_e     sew_i;
    vreg_t    vs1_i;
    vreg_t    vs2_i;
    vreg_t    vd_o;

    // stimulus and expected value table
    vmul_op_e    op_tab[$];
    sew_e        sew_tab[$];
    logic [63:0] vs1_tab[$];
    logic [63:0] vs2_tab[$];
    logic [63:0] exp_tab[$];

    // results in flight with the oldest at the front
    int          due_q[$];
    int          row_q[$];
    logic [63:0] exp_q[$];

    vmul_top vmul_top_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .op_i   (op_i),
        .sew_i  (sew_i),
        .vs1_i  (vs1_i),
        .vs2_i  (vs2_i),
        .vd_o   (vd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////

    // exact lane products on sign-extended 128-bit values
    function automatic logic [63:0] model_vmul(input vmul_op_e op, input sew_e sew,
                                               input logic [63:0] a, input logic [63:0] b);
        int           ew;
        int           nl;
        logic         sgn1;
        logic         sgn2;
        logic         hi;
        logic         wide;
        logic [127:0] mask;
        logic [127:0] x1;
        logic [127:0] x2;
        logic [127:0] p;
        logic [127:0] acc;
        ew   = 8 << int'(sew);
        nl   = 64 / ew;
        sgn1 = (op == VMUL) || (op == VMULH) || (op == VWMUL);
        sgn2 = sgn1 || (op == VMULHSU) || (op == VWMULSU);
        hi   = (op == VMULH) || (op == VMULHU) || (op == VMULHSU);
        // widening at 64 bits has no wider destination
        wide = ((op == VWMUL) || (op == VWMULU) || (op == VWMULSU)) && (ew < 64);
        mask = (128'd1 << ew) - 128'd1;
        acc  = '0;
        for (int i = 0; i < nl; i++) begin
            x1 = ({64'd0, a} >> (i * ew)) & mask;
            x2 = ({64'd0, b} >> (i * ew)) & mask;
            if (sgn1 && x1[ew-1]) x1 = x1 | ~mask;
            if (sgn2 && x2[ew-1]) x2 = x2 | ~mask;
            p = x1 * x2;
            if (wide) begin
                if (i < nl / 2) begin
                    acc = acc | ((p & ((128'd1 << (2 * ew)) - 128'd1)) << (2 * ew * i));
                end
            end else if (hi) begin
                acc = acc | (((p >> ew) & mask) << (ew * i));
            end else begin
                acc = acc | ((p & mask) << (ew * i));
            end
        end
        return acc[63:0];
    endfunction

    task automatic add_row(input vmul_op_e op, input sew_e sew,
                           input logic [63:0] a, input logic [63:0] b);
        op_tab.push_back(op);
        sew_tab.push_back(sew);
        vs1_tab.push_back(a);
        vs2_tab.push_back(b);
        exp_tab.push_back(model_vmul(op, sew, a, b));
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic wait_reset_release();
        int released;
        released = 0;
        for (int n = 0; n < RESET_TIMEOUT && released == 0; n++) begin
            @(negedge clk_i);
            if (rstn_i) released = 1;
        end
        if (released == 0) fail_run("reset was never released, giving up");
    endtask

    //////////////////////////////////////////////////
    // table setup
    //////////////////////////////////////////////////

    task automatic build_table();
        logic [63:0] a;
        logic [63:0] b;
        // low half with extreme and mixed-sign lanes
        add_row(VMUL, SEW_8,  64'h807f_ff01_80fe_05fb, 64'h8080_ff7f_01fe_fb05);
        add_row(VMUL, SEW_16, 64'h8000_7fff_ffff_0003, 64'h8000_8000_7fff_fffd);
        add_row(VMUL, SEW_32, 64'h8000_0000_7fff_ffff, 64'h8000_0000_8000_0001);
        add_row(VMUL, SEW_64, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        add_row(VMUL, SEW_64, 64'hffff_ffff_ffff_fffd, 64'h1234_5678_9abc_def0);
        // same operands read as signed, unsigned and mixed
        a = 64'hf00d_8001_7fff_c3a5;
        b = 64'h8000_ffff_0123_9e37;
        for (int s = 0; s < 4; s++) begin
            add_row(VMULH,   sew_e'(s), a, b);
            add_row(VMULHU,  sew_e'(s), a, b);
            add_row(VMULHSU, sew_e'(s), a, b);
        end
        // widened lower lanes
        for (int s = 0; s < 3; s++) begin
            add_row(VWMUL,   sew_e'(s), 64'h0000_0000_8000_ff7f, 64'h0000_0000_8000_0181);
            add_row(VWMULU,  sew_e'(s), 64'h0000_0000_8000_ff7f, 64'h0000_0000_8000_0181);
            add_row(VWMULSU, sew_e'(s), 64'h0000_0000_8000_ff7f, 64'h0000_0000_8000_0181);
        end
        add_row(VWMUL, SEW_64, 64'hffff_ffff_ffff_fff0, 64'h0000_0000_0000_0011);
        // width and operation change on every cycle
        add_row(VMULHU, SEW_64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
        add_row(VWMULU, SEW_8,  64'h0000_0000_ffff_ffff, 64'h0000_0000_ffff_ffff);
        add_row(VMULH,  SEW_32, 64'h8000_0000_8000_0000, 64'h7fff_ffff_8000_0000);
        add_row(VMUL,   SEW_16, 64'hfffe_0002_8001_7ffe, 64'h0003_fffd_8001_0002);
        // random rows over all operations and widths
        for (int n = 0; n < NUM_RANDOM; n++) begin
            add_row(vmul_op_e'($urandom % 7), sew_e'($urandom % 4),
                    {$urandom, $urandom}, {$urandom, $urandom});
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int num_rows;
        rstn_i = 1'b0;
        op_i   = VMUL;
        sew_i  = SEW_8;
        vs1_i  = '0;
        vs2_i  = '0;
        void'($urandom(32'ha56));
        build_table();
        num_rows = op_tab.size();

        @(posedge clk_i);
        @(negedge clk_i);
        check_value("vd_o in reset", vd_o, 64'd0);
        @(posedge clk_i);
        rstn_i <= 1'b1;
        wait_reset_release();

        for (int c = 0; c < num_rows + 2; c++) begin
            @(posedge clk_i);
            if (c < num_rows) begin
                op_i  <= op_tab[c];
                sew_i <= sew_tab[c];
                vs1_i <= vs1_tab[c];
                vs2_i <= vs2_tab[c];
                due_q.push_back(c + 2);
                row_q.push_back(c);
                exp_q.push_back(exp_tab[c]);
            end
            @(negedge clk_i);
            if (due_q.size() > 0 && due_q[0] == c) begin
                check_value($sformatf("vd_o row %0d", row_q[0]), vd_o, exp_q[0]);
                void'(due_q.pop_front());
                void'(row_q.pop_front());
                void'(exp_q.pop_front());
            end else begin
                // nothing due yet so the output still holds the reset value
                check_value("vd_o before first result", vd_o, 64'd0);
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
vmul_op_pkg.sv
vmul_data_pkg.sv
vmul_operand_prep.sv
vmul_partial_array.sv
vmul_result_assemble.sv
vmul_top.sv
tb_vmul_top.sv

// ==== Bender.yml ====
package:
  name: vmul

sources:
  - include_dirs:
      - .
    files:
      - vmul_op_pkg.sv
      - vmul_data_pkg.sv
      - vmul_operand_prep.sv
      - vmul_partial_array.sv
      - vmul_result_assemble.sv
      - vmul_top.sv
  - target: test
    files:
      - tb_vmul_top.sv
